//--- all.f
+incdir+src
src/lsu_pkg.sv
src/mem_op_decoder.sv
src/byte_lane_bank.sv
src/load_aligner.sv
src/lsu_top.sv
sim/tb_clock_gen.sv
sim/lsu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f all.f \
    --top-module lsu_tb \
    --Mdir obj_dir \
    -o lsu_sim

status=0
./obj_dir/lsu_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx "SIMULATION PASSED" sim.log; then
    exit 0
fi
echo "run.sh: simulation did not report success (exit status $status)"
exit 1

//--- sim/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_tb
    import lsu_pkg::*;
();

    localparam int MEM_BYTES     = `LSU_MEM_WORDS * `LSU_LANES;
    localparam int RESET_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT = 20;
    localparam int RANDOM_OPS    = 2000;

    // One expected output pulse and the cycle it is due in
    typedef struct packed {
        logic [31:0] due;
        logic        is_load;
        word_t       data;
    } exp_t;

    logic       clk;
    logic       rst_n;
    logic       req;
    mem_uop_t   uop;
    word_t      addr;
    word_t      wdata;
    logic       load_valid;
    word_t      load_data;
    logic       misalign;

    logic [7:0]  ref_mem [MEM_BYTES];   // Byte-level reference memory
    exp_t        exp_q[$];
    logic [31:0] cycle;
    int          errors;
    int          checks;
    int          test_num;
    int          failed_tests;
    int          err_start;
    string       test_name;

    tb_clock_gen u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    lsu_top DUT (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .req_i        (req),
        .uop_i        (uop),
        .addr_i       (addr),
        .wdata_i      (wdata),
        .load_valid_o (load_valid),
        .load_data_o  (load_data),
        .misalign_o   (misalign)
    );

    function automatic mem_uop_t pick_uop(logic [31:0] n);
        case (n)
            32'd0:   return NOP;
            32'd1:   return LB;
            32'd2:   return LBU;
            32'd3:   return LH;
            32'd4:   return LHU;
            32'd5:   return LW;
            32'd6:   return SB;
            32'd7:   return SH;
            default: return SW;
        endcase
    endfunction

    // Halfword not at offset 3, word only at offset 0
    function automatic logic misaligned(mem_uop_t op, logic [1:0] off);
        case (op)
            LH, LHU, SH: return off == 2'd3;
            LW, SW:      return off != 2'd0;
            default:     return 1'b0;
        endcase
    endfunction

    function automatic logic [9:0] byte_index(word_t a, logic [1:0] k);
        logic [1:0] lane;
        lane = a[1:0] + k;
        return {a[9:2], lane};
    endfunction

    task automatic check_load(input logic valid, input word_t got, input word_t exp);
        checks++;
        if (valid !== 1'b1) begin
            $display("load result missing at %0t, expected %h", $time, exp);
            errors++;
        end else if (got !== exp) begin
            $display("mismatch at %0t: load data %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_misalign(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t: misalign_o %b, expected %b", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_quiet(input logic valid);
        checks++;
        if (valid !== 1'b0) begin
            $display("unexpected load_valid_o pulse at %0t", $time);
            errors++;
        end
    endtask

    // Compare the outputs of this cycle with the head of the queue
    task automatic check_outputs();
        exp_t e;
        if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
            e = exp_q.pop_front();
            if (e.is_load) begin
                check_load(load_valid, load_data, e.data);
                check_misalign(misalign, 1'b0);
            end else begin
                check_misalign(misalign, 1'b1);
                check_quiet(load_valid);
            end
        end else begin
            check_quiet(load_valid);
            check_misalign(misalign, 1'b0);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
        cycle++;
        check_outputs();
    endtask

    // Applies one operation to the reference memory and queues its result
    task automatic model_op(input mem_uop_t op, input word_t a, input word_t d);
        exp_t       e;
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        b0 = ref_mem[byte_index(a, 2'd0)];
        b1 = ref_mem[byte_index(a, 2'd1)];
        b2 = ref_mem[byte_index(a, 2'd2)];
        b3 = ref_mem[byte_index(a, 2'd3)];
        e.due = cycle + 32'd2;       // Fixed two-cycle latency
        e.is_load = 1'b0;
        e.data = '0;
        if (op == NOP) begin
            e.due = 32'd0;
        end else if (misaligned(op, a[1:0])) begin
            exp_q.push_back(e);
        end else begin
            case (op)
                LB:  e.data = {{24{b0[7]}}, b0};
                LBU: e.data = {24'd0, b0};
                LH:  e.data = {{16{b1[7]}}, b1, b0};
                LHU: e.data = {16'd0, b1, b0};
                LW:  e.data = {b3, b2, b1, b0};
                SB: begin
                    ref_mem[byte_index(a, 2'd0)] = d[7:0];
                end
                SH: begin
                    ref_mem[byte_index(a, 2'd0)] = d[7:0];
                    ref_mem[byte_index(a, 2'd1)] = d[15:8];
                end
                default: begin
                    ref_mem[byte_index(a, 2'd0)] = d[7:0];
                    ref_mem[byte_index(a, 2'd1)] = d[15:8];
                    ref_mem[byte_index(a, 2'd2)] = d[23:16];
                    ref_mem[byte_index(a, 2'd3)] = d[31:24];
                end
            endcase
            e.is_load = (op == LB) || (op == LBU) || (op == LH) || (op == LHU) || (op == LW);
            if (e.is_load) begin
                exp_q.push_back(e);
            end
        end
    endtask

    task automatic issue_op(input mem_uop_t op, input word_t a, input word_t d);
        req = 1'b1;
        uop = op;
        addr = a;
        wdata = d;
        model_op(op, a, d);
        step();
    endtask

    task automatic idle();
        req = 1'b0;
        uop = NOP;
        addr = '0;
        wdata = '0;
        step();
    endtask

    // Run idle cycles until every queued result has been seen
    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < DRAIN_TIMEOUT) begin
            idle();
            n++;
        end
        if (exp_q.size() > 0) begin
            $display("timeout: %0d expected results never arrived", exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < RESET_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset still asserted after %0d cycles", n);
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic start_test(input string name);
        test_num++;
        test_name = name;
        err_start = errors;
    endtask

    task automatic end_test();
        if (errors == err_start) begin
            $display("test %0d %s: ok", test_num, test_name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, test_name, errors - err_start);
            failed_tests++;
        end
    endtask

    initial begin
        logic [31:0] rnd_op;
        logic [31:0] rnd_addr;
        logic [31:0] rnd_data;
        logic [31:0] rnd_req;
        word_t       a;
        rnd_op = $urandom(93);   // Seed once for the whole run
        req = 1'b0;
        uop = NOP;
        addr = '0;
        wdata = '0;
        cycle = '0;
        errors = 0;
        checks = 0;
        test_num = 0;
        failed_tests = 0;
        err_start = 0;

        wait_reset();

        start_test("quiet after reset");
        repeat (8) idle();
        end_test();

        start_test("word store and load");
        issue_op(SW, 32'h0000_0010, 32'hdead_beef);
        issue_op(LW, 32'h0000_0010, 32'h0);
        drain();
        issue_op(SW, 32'h0000_0010, 32'h1234_5678);
        issue_op(LW, 32'h0000_0010, 32'h0);   // Right behind the store
        drain();
        end_test();

        start_test("byte and halfword merge");
        issue_op(SW, 32'h0000_0020, 32'h1122_3344);
        issue_op(SB, 32'h0000_0021, 32'h0000_00aa);
        issue_op(SH, 32'h0000_0022, 32'h0000_beef);
        issue_op(LW, 32'h0000_0020, 32'h0);
        issue_op(SW, 32'h0000_0024, 32'h0);
        issue_op(SH, 32'h0000_0025, 32'h0000_5566);   // Halfword at offset 1
        issue_op(LW, 32'h0000_0024, 32'h0);
        drain();
        end_test();

        start_test("sign and zero extension");
        issue_op(SW, 32'h0000_0030, 32'h05f0_7f81);
        issue_op(SW, 32'h0000_0034, 32'h7f80_01fe);
        for (int off = 0; off < 4; off++) begin
            a = 32'h0000_0030 + word_t'(off);
            issue_op(LB, a, 32'h0);
            issue_op(LBU, a, 32'h0);
            a = 32'h0000_0034 + word_t'(off);
            issue_op(LB, a, 32'h0);
            issue_op(LBU, a, 32'h0);
        end
        for (int off = 0; off < 3; off++) begin
            a = 32'h0000_0030 + word_t'(off);
            issue_op(LH, a, 32'h0);
            issue_op(LHU, a, 32'h0);
            a = 32'h0000_0034 + word_t'(off);
            issue_op(LH, a, 32'h0);
            issue_op(LHU, a, 32'h0);
        end
        drain();
        end_test();

        start_test("misaligned accesses");
        issue_op(SW, 32'h0000_0040, 32'hcafe_f00d);
        issue_op(SW, 32'h0000_0044, 32'h0bad_c0de);
        issue_op(SH, 32'h0000_0043, 32'h0000_ffff);
        issue_op(SW, 32'h0000_0042, 32'hffff_ffff);
        issue_op(SW, 32'h0000_0041, 32'hffff_ffff);
        issue_op(LH, 32'h0000_0043, 32'h0);
        issue_op(LHU, 32'h0000_0047, 32'h0);
        issue_op(LW, 32'h0000_0041, 32'h0);
        issue_op(LW, 32'h0000_0043, 32'h0);
        issue_op(LW, 32'h0000_0040, 32'h0);   // Memory must be untouched
        issue_op(LW, 32'h0000_0044, 32'h0);
        drain();
        end_test();

        start_test("random mix");
        // Fill the 64-byte window first so no load sees unwritten memory
        for (int w = 0; w < 16; w++) begin
            rnd_data = $urandom;
            issue_op(SW, word_t'(w * 4), rnd_data);
        end
        for (int i = 0; i < RANDOM_OPS; i++) begin
            rnd_op = $urandom;
            rnd_addr = $urandom;
            rnd_data = $urandom;
            rnd_req = $urandom;
            // Upper bits random, bits 9..6 clear, so all hits land in the window
            a = {rnd_addr[31:10], 4'b0000, rnd_addr[5:0]};
            if (rnd_req[2:0] == 3'd0) begin
                idle();
            end else begin
                issue_op(pick_uop(rnd_op % 32'd9), a, rnd_data);
            end
        end
        drain();
        end_test();

        $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
                 test_num, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD = 5;   // 10 ns clock
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Reset released just after a rising edge, like the other inputs
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- src/byte_lane_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module byte_lane_bank (
    input  wire logic                               clk_i,
    input  wire logic                               we_i,
    input  wire logic                               re_i,
    input  wire logic [$clog2(`LSU_MEM_WORDS)-1:0]  addr_i,
    input  wire logic [7:0]                         wdata_i,
    output logic [7:0]                              rdata_o
);

    // One byte per word of the data memory
    logic [7:0] mem [`LSU_MEM_WORDS];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        if (re_i) begin
            rdata_o <= mem[addr_i]; // Held until the next read
        end
    end

    // Enables come from the decoder, X before its reset edge
    a_we_re_excl: assert property (@(posedge clk_i)
        !((we_i === 1'b1) && (re_i === 1'b1)))
        else $error("bank write and read in the same cycle");

endmodule

`default_nettype wire

//--- src/load_aligner.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module load_aligner
    import lsu_pkg::*;
(
    input  wire logic          clk_i,
    input  wire logic          rst_n_i,
    input  wire word_t         lane_rdata_i,
    input  wire logic          ld_i,
    input  wire logic          ld_signed_i,
    input  wire access_size_t  size_i,
    input  wire logic [1:0]    offset_i,
    input  wire logic          misalign_i,
    output logic               load_valid_o,
    output word_t              load_data_o,
    output logic               misalign_o
);

    logic         ld_q;
    logic         misalign_q;
    logic         signed_q;
    access_size_t size_q;
    logic [1:0]   offset_q;
    word_t        shifted;
    logic         sign_bit;

    // Control delayed one stage to meet the bank read data
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ld_q       <= 1'b0;
            misalign_q <= 1'b0;
        end else begin
            ld_q       <= ld_i;
            misalign_q <= misalign_i;
        end
    end

    always_ff @(posedge clk_i) begin
        signed_q <= ld_signed_i;
        size_q   <= size_i;
        offset_q <= offset_i;
    end

    // Addressed bytes down to lane 0
    assign shifted = lane_rdata_i >> {offset_q, 3'b000};

    always_comb begin
        sign_bit = 1'b0;
        case (size_q)
            SIZE_BYTE: begin
                sign_bit    = signed_q & shifted[7];
                load_data_o = {{(`LSU_XLEN-8){sign_bit}}, shifted[7:0]};
            end
            SIZE_HALF: begin
                sign_bit    = signed_q & shifted[15];
                load_data_o = {{(`LSU_XLEN-16){sign_bit}}, shifted[15:0]};
            end
            default: begin
                load_data_o = shifted; // Full word, no extension
            end
        endcase
    end

    assign load_valid_o = ld_q;
    assign misalign_o   = misalign_q;

    // Decoder drops the load strobe for a misaligned access
    a_valid_misalign_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(load_valid_o && misalign_o))
        else $error("load result and misalign flagged together");

endmodule

`default_nettype wire

//--- src/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Data word width in bits
`define LSU_XLEN 32

// Byte lanes in one data word
`define LSU_LANES 4

// Memory depth in words, index taken from address bits 9..2
`define LSU_MEM_WORDS 256

`endif

//--- src/lsu_pkg.sv
`default_nettype none

`include "lsu_consts.svh"

package lsu_pkg;

    // Memory micro-operations accepted by the data path
    typedef enum logic [3:0] {
        NOP = 4'd0,
        LB  = 4'd1,
        LBU = 4'd2,
        LH  = 4'd3,
        LHU = 4'd4,
        LW  = 4'd5,
        SB  = 4'd6,
        SH  = 4'd7,
        SW  = 4'd8
    } mem_uop_t;

    // Width of one access
    typedef enum logic [1:0] {
        SIZE_NONE = 2'd0,
        SIZE_BYTE = 2'd1,
        SIZE_HALF = 2'd2,
        SIZE_WORD = 2'd3
    } access_size_t;

    typedef logic [`LSU_XLEN-1:0]  word_t;      // Store data, lane data, load result
    typedef logic [`LSU_LANES-1:0] byte_mask_t; // Bit k enables lane k

endpackage

`default_nettype wire

//--- src/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    input  wire logic      req_i,
    input  wire mem_uop_t  uop_i,
    input  wire word_t     addr_i,
    input  wire word_t     wdata_i,
    output logic           load_valid_o,
    output word_t          load_data_o,
    output logic           misalign_o
);

    localparam int LANE_W = `LSU_XLEN / `LSU_LANES;

    byte_mask_t                         lane_we;
    byte_mask_t                         lane_re;
    word_t                              lane_wdata;
    word_t                              lane_rdata;
    logic [$clog2(`LSU_MEM_WORDS)-1:0]  word_idx;
    logic                               dec_ld;
    logic                               dec_signed;
    access_size_t                       dec_size;
    logic [1:0]                         dec_offset;
    logic                               dec_misalign;

    mem_op_decoder u_decoder (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .uop_i        (uop_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .lane_we_o    (lane_we),
        .lane_re_o    (lane_re),
        .lane_wdata_o (lane_wdata),
        .word_idx_o   (word_idx),
        .ld_o         (dec_ld),
        .ld_signed_o  (dec_signed),
        .size_o       (dec_size),
        .offset_o     (dec_offset),
        .misalign_o   (dec_misalign)
    );

    // One bank per byte lane
    for (genvar i = 0; i < `LSU_LANES; i++) begin : g_lane
        byte_lane_bank u_bank (
            .clk_i   (clk_i),
            .we_i    (lane_we[i]),
            .re_i    (lane_re[i]),
            .addr_i  (word_idx),
            .wdata_i (lane_wdata[LANE_W*i +: LANE_W]),
            .rdata_o (lane_rdata[LANE_W*i +: LANE_W])
        );
    end

    load_aligner u_aligner (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .lane_rdata_i (lane_rdata),
        .ld_i         (dec_ld),
        .ld_signed_i  (dec_signed),
        .size_i       (dec_size),
        .offset_i     (dec_offset),
        .misalign_i   (dec_misalign),
        .load_valid_o (load_valid_o),
        .load_data_o  (load_data_o),
        .misalign_o   (misalign_o)
    );

endmodule

`default_nettype wire

//--- src/mem_op_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module mem_op_decoder
    import lsu_pkg::*;
(
    input  wire logic                                clk_i,
    input  wire logic                                rst_n_i,
    input  wire logic                                req_i,
    input  wire mem_uop_t                            uop_i,
    input  wire word_t                               addr_i,
    input  wire word_t                               wdata_i,
    output byte_mask_t                               lane_we_o,
    output byte_mask_t                               lane_re_o,
    output word_t                                    lane_wdata_o,
    output logic [$clog2(`LSU_MEM_WORDS)-1:0]        word_idx_o,
    output logic                                     ld_o,
    output logic                                     ld_signed_o,
    output access_size_t                             size_o,
    output logic [1:0]                               offset_o,
    output logic                                     misalign_o
);

    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);

    access_size_t size_d;
    logic         rd_d;
    logic         wr_d;
    logic         signed_d;
    logic [1:0]   offset;
    byte_mask_t   mask_d;
    logic         misalign_d;
    logic         go_d;        // Legal operation that touches the banks

    // Lanes offset .. offset+size-1
    function automatic byte_mask_t mask_sel(access_size_t size, logic [1:0] off);
        byte_mask_t m;
        case (size)
            SIZE_BYTE: m = byte_mask_t'(4'b0001) << off;
            SIZE_HALF: m = byte_mask_t'(4'b0011) << off;
            SIZE_WORD: m = byte_mask_t'(4'b1111) << off;
            default:   m = '0;
        endcase
        return m;
    endfunction

    assign offset = addr_i[1:0];

    always_comb begin
        size_d   = SIZE_NONE;
        rd_d     = 1'b0;
        wr_d     = 1'b0;
        signed_d = 1'b0;
        case (uop_i)
            LB: begin
                size_d   = SIZE_BYTE;
                rd_d     = 1'b1;
                signed_d = 1'b1;
            end
            LBU: begin
                size_d = SIZE_BYTE;
                rd_d   = 1'b1;
            end
            LH: begin
                size_d   = SIZE_HALF;
                rd_d     = 1'b1;
                signed_d = 1'b1;
            end
            LHU: begin
                size_d = SIZE_HALF;
                rd_d   = 1'b1;
            end
            LW: begin
                size_d = SIZE_WORD;
                rd_d   = 1'b1;
            end
            SB: begin
                size_d = SIZE_BYTE;
                wr_d   = 1'b1;
            end
            SH: begin
                size_d = SIZE_HALF;
                wr_d   = 1'b1;
            end
            SW: begin
                size_d = SIZE_WORD;
                wr_d   = 1'b1;
            end
            default: ; // NOP keeps the defaults
        endcase
    end

    assign mask_d = mask_sel(size_d, offset);

    // Halfword may not start at offset 3, word only at offset 0
    assign misalign_d = req_i &&
                        (((size_d == SIZE_HALF) && (offset == 2'd3)) ||
                         ((size_d == SIZE_WORD) && (offset != 2'd0)));

    assign go_d = req_i && (size_d != SIZE_NONE) && !misalign_d;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lane_we_o  <= '0;
            lane_re_o  <= '0;
            ld_o       <= 1'b0;
            misalign_o <= 1'b0;
        end else begin
            lane_we_o  <= mask_d & {`LSU_LANES{go_d & wr_d}};
            lane_re_o  <= mask_d & {`LSU_LANES{go_d & rd_d}};
            ld_o       <= go_d & rd_d;
            misalign_o <= misalign_d;
        end
    end

    // Payload, qualified by the strobes above
    always_ff @(posedge clk_i) begin
        lane_wdata_o <= wdata_i << {offset, 3'b000}; // Store bytes onto their lanes
        word_idx_o   <= addr_i[IDX_W+1:2];
        ld_signed_o  <= signed_d;
        size_o       <= size_d;
        offset_o     <= offset;
    end

    a_we_re_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !((|lane_we_o) && (|lane_re_o)))
        else $error("lane write and read enables both active");

    a_misalign_no_en: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        misalign_o |-> ((lane_we_o == '0) && (lane_re_o == '0)))
        else $error("misaligned operation reached the banks");

endmodule

`default_nettype wire
